/* common/fma_cfg_pkg.sv */
// ***************************************************************************
// datapath sizes and lane layout
// ***************************************************************************

package fma_cfg_pkg;

   localparam int OP_W        = 32;   // x, y, z and w operands.
   localparam int PROD_W      = 64;   // full product and result.
   localparam int LANES       = 4;    // accumulator lanes.
   localparam int LANE_W      = 2;    // lane select width.
   localparam int MUL_LAT_DEF = 2;    // multiplier pipeline depth.

   typedef logic [OP_W-1:0]   operand_t;
   typedef logic [PROD_W-1:0] prod_t;
   typedef logic [LANE_W-1:0] lane_t;

endpackage

/* common/fma_cmd_pkg.sv */
// ***************************************************************************
// request commands and result flags
// ***************************************************************************

package fma_cmd_pkg;

   typedef enum logic [1:0] {
      CMD_MADD = 2'd0,   // x*y + z.
      CMD_MSUB = 2'd1,   // x*y - z.
      CMD_MAC  = 2'd2,   // lane += low word of x*y.
      CMD_CLR  = 2'd3    // lane cleared.
   } cmd_e;

   typedef logic [1:0] flag_t;

   localparam int FLAG_NEG  = 0;   // msub result below zero.
   localparam int FLAG_WRAP = 1;   // mac lane carried out.

endpackage

/* common/fma_if.sv */
// ***************************************************************************
// multiplier port
// ***************************************************************************

interface mul_port_if;
   import fma_cfg_pkg::*;

   logic     en;
   operand_t a;
   operand_t b;
   prod_t    prod;
   logic     valid;

   modport master (output en, a, b, input valid);
   modport slave  (input en, a, b, output prod, valid);
endinterface

// ***************************************************************************
// adder port
// ***************************************************************************

interface add_port_if;
   import fma_cfg_pkg::*;
   import fma_cmd_pkg::*;

   logic  en;
   cmd_e  cmd;
   prod_t a;      // product, wired at the top.
   prod_t b;      // z, zero extended.
   prod_t sum;
   flag_t flag;

   modport master (output en, cmd, b);
   modport slave  (input en, cmd, a, b, output sum, flag);
endinterface

/* datapath/mul_pipe.sv */
module mul_pipe #(
   parameter int MUL_LAT = fma_cfg_pkg::MUL_LAT_DEF
) (
   input logic       clk_i,
   input logic       rst_i,
   mul_port_if.slave mul_s
);
   import fma_cfg_pkg::*;

   prod_t              prod_q [MUL_LAT];
   logic [MUL_LAT-1:0] vld_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         vld_q <= '0;
      end else begin
         vld_q[0] <= mul_s.en;
         for (int i = 1; i < MUL_LAT; i++) begin
            vld_q[i] <= vld_q[i-1];
         end
      end
   end

   // a stage loads only behind a valid, so the last product holds.
   always_ff @(posedge clk_i) begin
      if (mul_s.en) begin
         prod_q[0] <= PROD_W'(mul_s.a) * PROD_W'(mul_s.b);
      end
      for (int i = 1; i < MUL_LAT; i++) begin
         if (vld_q[i-1]) begin
            prod_q[i] <= prod_q[i-1];
         end
      end
   end

   assign mul_s.prod  = prod_q[MUL_LAT-1];
   assign mul_s.valid = vld_q[MUL_LAT-1];

endmodule

/* datapath/add_stage.sv */
module add_stage (
   input logic       clk_i,
   input logic       rst_i,
   input logic       wrap_i,   // lane carry from the accumulators.
   add_port_if.slave add_s
);
   import fma_cfg_pkg::*;
   import fma_cmd_pkg::*;

   prod_t sum_q;
   prod_t diff;
   logic  neg_q;

   assign diff = add_s.a - add_s.b;

   always_ff @(posedge clk_i) begin
      if (add_s.en) begin
         if (add_s.cmd == CMD_MSUB) begin
            sum_q <= diff;
         end else begin
            sum_q <= add_s.a + add_s.b;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         neg_q <= 1'b0;
      end else if (add_s.en) begin
         neg_q <= (add_s.cmd == CMD_MSUB) && diff[PROD_W-1];   // two's complement sign.
      end
   end

   assign add_s.sum = sum_q;

   // one flag word for the controller, whatever the command.
   always_comb begin
      add_s.flag = '0;
      if (add_s.cmd == CMD_MSUB) begin
         add_s.flag[FLAG_NEG] = neg_q;
      end
      if (add_s.cmd == CMD_MAC) begin
         add_s.flag[FLAG_WRAP] = wrap_i;
      end
   end

endmodule

/* datapath/acc_bank.sv */
module acc_bank (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  wr_en_i,
   input  logic                  clr_en_i,
   input  fma_cfg_pkg::lane_t    lane_i,
   input  fma_cfg_pkg::operand_t addend_i,
   output fma_cfg_pkg::operand_t acc_o [fma_cfg_pkg::LANES],
   output logic                  wrap_o
);
   import fma_cfg_pkg::*;

   operand_t      acc_q [LANES];
   logic [OP_W:0] sum_ext;
   logic          wrap_q;

   assign sum_ext = {1'b0, acc_q[lane_i]} + {1'b0, addend_i};

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         for (int i = 0; i < LANES; i++) begin
            acc_q[i] <= '0;
         end
         wrap_q <= 1'b0;
      end else if (wr_en_i) begin
         acc_q[lane_i] <= sum_ext[OP_W-1:0];
         wrap_q        <= sum_ext[OP_W];
      end else if (clr_en_i) begin
         acc_q[lane_i] <= '0;
         wrap_q        <= 1'b0;
      end
   end

   // live carry while writing, so the flag lands with the new lane value.
   always_comb begin
      if (wr_en_i) begin
         wrap_o = sum_ext[OP_W];
      end else if (clr_en_i) begin
         wrap_o = 1'b0;
      end else begin
         wrap_o = wrap_q;
      end
   end

   assign acc_o = acc_q;

endmodule

/* hdl/step_timer.sv */
module step_timer #(
   parameter int MUL_LAT = fma_cfg_pkg::MUL_LAT_DEF
) (
   input  logic clk_i,
   input  logic rst_i,
   input  logic start_i,
   output logic expire_o
);

   localparam int CNT_W = (MUL_LAT > 1) ? $clog2(MUL_LAT) : 1;

   logic [CNT_W-1:0] cnt_q;
   logic             run_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cnt_q <= '0;
         run_q <= 1'b0;
      end else if (start_i) begin
         cnt_q <= CNT_W'(MUL_LAT - 1);
         run_q <= 1'b1;
      end else if (run_q) begin
         if (cnt_q == '0) begin
            run_q <= 1'b0;          // one pulse per start.
         end else begin
            cnt_q <= cnt_q - 1'b1;
         end
      end
   end

   assign expire_o = run_q && (cnt_q == '0);

endmodule

/* hdl/fma_ctrl.sv */
module fma_ctrl #(
   parameter int MUL_LAT = fma_cfg_pkg::MUL_LAT_DEF
) (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  req_i,
   input  fma_cmd_pkg::cmd_e     cmd_i,
   input  fma_cfg_pkg::operand_t x_i,
   input  fma_cfg_pkg::operand_t y_i,
   input  fma_cfg_pkg::operand_t z_i,
   input  fma_cfg_pkg::lane_t    lane_i,
   input  logic                  expire_i,
   input  fma_cfg_pkg::prod_t    add_sum_i,
   input  fma_cmd_pkg::flag_t    add_flag_i,
   output logic                  start_o,
   output logic                  busy_o,
   output logic                  done_o,
   output fma_cfg_pkg::prod_t    rslt_o,
   output fma_cmd_pkg::flag_t    flag_o,
   output logic                  acc_wr_o,
   output logic                  acc_clr_o,
   output fma_cfg_pkg::lane_t    acc_lane_o,
   mul_port_if.master            mul_m,
   add_port_if.master            add_m
);
   import fma_cfg_pkg::*;
   import fma_cmd_pkg::*;

   typedef enum logic [1:0] {S_IDLE, S_MUL, S_ADD, S_DONE} state_e;

   state_e   state_q;
   state_e   state_d;
   cmd_e     cmd_q;
   operand_t z_q;
   lane_t    lane_q;
   logic     accept;
   logic     arith;

   if (MUL_LAT < 1) begin : g_lat_check
      $fatal(1, "fma_ctrl: MUL_LAT must be 1 or more");
   end

   assign accept = (state_q == S_IDLE) && req_i;   // later requests are dropped.
   assign arith  = (cmd_q == CMD_MADD) || (cmd_q == CMD_MSUB);

   // ************************************************************************
   // sequencing
   // ************************************************************************

   always_comb begin
      state_d = state_q;
      case (state_q)
         S_IDLE: begin
            if (req_i) begin
               state_d = S_MUL;
            end
         end
         S_MUL: begin
            if (expire_i) begin   // last multiplier cycle.
               state_d = S_ADD;
            end
         end
         S_ADD:   state_d = S_DONE;
         default: state_d = S_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= S_IDLE;
         cmd_q   <= CMD_MADD;
         rslt_o  <= '0;
         flag_o  <= '0;
      end else begin
         state_q <= state_d;
         if (accept) begin
            cmd_q <= cmd_i;
         end
         if (state_q == S_ADD) begin    // visible in the done cycle.
            flag_o <= add_flag_i;
            if (arith) begin
               rslt_o <= add_sum_i;     // mac and clr keep the old result.
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         z_q    <= z_i;
         lane_q <= lane_i;
      end
   end

   // ************************************************************************
   // unit strobes
   // ************************************************************************

   assign start_o    = accept;
   assign busy_o     = (state_q != S_IDLE);
   assign done_o     = (state_q == S_DONE);
   assign acc_wr_o   = (state_q == S_ADD) && (cmd_q == CMD_MAC);
   assign acc_clr_o  = (state_q == S_ADD) && (cmd_q == CMD_CLR);
   assign acc_lane_o = lane_q;

   assign mul_m.en = accept;   // operands go in on the accepting edge.
   assign mul_m.a  = x_i;
   assign mul_m.b  = y_i;

   assign add_m.en  = (state_q == S_MUL) && expire_i && mul_m.valid && arith;
   assign add_m.cmd = cmd_q;
   assign add_m.b   = {{(PROD_W-OP_W){1'b0}}, z_q};

endmodule

/* hdl/fma_unit.sv */
module fma_unit #(
   parameter int MUL_LAT = fma_cfg_pkg::MUL_LAT_DEF
) (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  req_i,
   input  fma_cmd_pkg::cmd_e     req_command_i,
   input  fma_cfg_pkg::operand_t x_i,
   input  fma_cfg_pkg::operand_t y_i,
   input  fma_cfg_pkg::operand_t z_i,
   input  fma_cfg_pkg::operand_t w_i,
   output logic                  busy_o,
   output logic                  done_o,
   output fma_cfg_pkg::prod_t    rslt_o,
   output fma_cmd_pkg::flag_t    flag_o,
   output fma_cfg_pkg::operand_t acc0_o,
   output fma_cfg_pkg::operand_t acc1_o,
   output fma_cfg_pkg::operand_t acc2_o,
   output fma_cfg_pkg::operand_t acc3_o
);
   import fma_cfg_pkg::*;

   mul_port_if mul_bus ();
   add_port_if add_bus ();

   logic     start;
   logic     expire;
   logic     acc_wr;
   logic     acc_clr;
   logic     wrap;
   lane_t    acc_lane;
   operand_t acc [LANES];

   assign add_bus.a = mul_bus.prod;   // product goes straight into the adder.

   fma_ctrl #(.MUL_LAT(MUL_LAT)) i_fma_ctrl (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .req_i      (req_i),
      .cmd_i      (req_command_i),
      .x_i        (x_i),
      .y_i        (y_i),
      .z_i        (z_i),
      .lane_i     (w_i[LANE_W-1:0]),
      .expire_i   (expire),
      .add_sum_i  (add_bus.sum),
      .add_flag_i (add_bus.flag),
      .start_o    (start),
      .busy_o     (busy_o),
      .done_o     (done_o),
      .rslt_o     (rslt_o),
      .flag_o     (flag_o),
      .acc_wr_o   (acc_wr),
      .acc_clr_o  (acc_clr),
      .acc_lane_o (acc_lane),
      .mul_m      (mul_bus.master),
      .add_m      (add_bus.master)
   );

   step_timer #(.MUL_LAT(MUL_LAT)) i_step_timer (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .start_i  (start),
      .expire_o (expire)
   );

   mul_pipe #(.MUL_LAT(MUL_LAT)) i_mul_pipe (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .mul_s (mul_bus.slave)
   );

   add_stage i_add_stage (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .wrap_i (wrap),
      .add_s  (add_bus.slave)
   );

   acc_bank i_acc_bank (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .wr_en_i  (acc_wr),
      .clr_en_i (acc_clr),
      .lane_i   (acc_lane),
      .addend_i (mul_bus.prod[OP_W-1:0]),   // low product word.
      .acc_o    (acc),
      .wrap_o   (wrap)
   );

   assign acc0_o = acc[0];
   assign acc1_o = acc[1];
   assign acc2_o = acc[2];
   assign acc3_o = acc[3];

endmodule

/* sim/fma_chk.sv */
module fma_chk #(
   parameter int MUL_LAT = fma_cfg_pkg::MUL_LAT_DEF
) (
   input logic clk_i,
   input logic rst_i,
   input logic req_i,
   input logic busy_i,
   input logic done_i
);
   timeunit 1ns;
   timeprecision 1ps;

   int   fail_cnt = 0;
   logic accept;

   assign accept = req_i && !busy_i;   // same condition as the controller.

   done_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
      done_i |=> !done_i)
      else begin
         fail_cnt++;
         $error("done_o stayed high for more than one cycle");
      end

   idle_after_reset: assert property (@(posedge clk_i)
      rst_i |=> !busy_i && !done_i)
      else begin
         fail_cnt++;
         $error("busy_o or done_o high in the cycle after reset");
      end

   // done sampled exactly MUL_LAT+2 edges after the accepting edge.
   done_latency: assert property (@(posedge clk_i) disable iff (rst_i)
      accept |-> (!done_i)[*(MUL_LAT+2)] ##1 done_i)
      else begin
         fail_cnt++;
         $error("done_o did not follow the request after MUL_LAT+2 cycles");
      end

endmodule

/* sim/fma_mon.sv */
module fma_mon (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  req_i,
   input  fma_cmd_pkg::cmd_e     cmd_i,
   input  fma_cfg_pkg::operand_t x_i,
   input  fma_cfg_pkg::operand_t y_i,
   input  fma_cfg_pkg::operand_t z_i,
   input  fma_cfg_pkg::operand_t w_i,
   input  logic                  busy_i,
   input  logic                  done_i,
   input  fma_cfg_pkg::prod_t    rslt_i,
   input  fma_cmd_pkg::flag_t    flag_i,
   input  fma_cfg_pkg::operand_t acc0_i,
   input  fma_cfg_pkg::operand_t acc1_i,
   input  fma_cfg_pkg::operand_t acc2_i,
   input  fma_cfg_pkg::operand_t acc3_i,
   output int                    pass_cnt_o,
   output int                    fail_cnt_o,
   output int                    pend_cnt_o
);
   timeunit 1ns;
   timeprecision 1ps;
   import fma_cfg_pkg::*;
   import fma_cmd_pkg::*;

   typedef struct packed {
      cmd_e     cmd;
      operand_t x;
      operand_t y;
      operand_t z;
      lane_t    lane;
   } req_t;

   req_t                         pend_q [$];
   logic [LANES-1:0][OP_W-1:0]   lanes_m;    // model of the accumulators.
   logic [LANES-1:0][OP_W-1:0]   acc_seen;
   prod_t                        rslt_m;
   bit                           rst_seen;
   int                           test_cnt = 0;
   int                           pass_cnt = 0;
   int                           fail_cnt = 0;
   int                           pend_cnt = 0;

   assign acc_seen   = {acc3_i, acc2_i, acc1_i, acc0_i};
   assign pass_cnt_o = pass_cnt;
   assign fail_cnt_o = fail_cnt;
   assign pend_cnt_o = pend_cnt;

   // expected outcome of one command, straight from the command rules.
   function automatic void ref_op(input req_t r, inout logic [LANES-1:0][OP_W-1:0] lanes,
                                  inout prod_t rslt, output flag_t flag);
      prod_t    prod;
      operand_t old;
      prod = prod_t'(r.x) * prod_t'(r.y);
      flag = '0;
      case (r.cmd)
         CMD_MADD: rslt = prod + prod_t'(r.z);
         CMD_MSUB: begin
            rslt = prod - prod_t'(r.z);
            flag[FLAG_NEG] = rslt[PROD_W-1];
         end
         CMD_MAC: begin
            old = lanes[r.lane];
            lanes[r.lane] = old + prod[OP_W-1:0];
            flag[FLAG_WRAP] = (lanes[r.lane] < old);   // a smaller sum means it carried.
         end
         default: lanes[r.lane] = '0;
      endcase
   endfunction

   task automatic compare_word(input string name, input prod_t got, input prod_t exp,
                               inout bit ok);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
         ok = 1'b0;
      end
   endtask

   task automatic compare_outputs(input flag_t flag_exp, inout bit ok);
      compare_word("rslt_o", rslt_i, rslt_m, ok);
      compare_word("flag_o", prod_t'(flag_i), prod_t'(flag_exp), ok);
      for (int i = 0; i < LANES; i++) begin
         compare_word($sformatf("acc%0d_o", i), prod_t'(acc_seen[i]), prod_t'(lanes_m[i]), ok);
      end
   endtask

   always @(posedge clk_i) begin
      req_t  r;
      flag_t flag_m;
      bit    ok;
      if (rst_i) begin
         pend_q.delete();
         lanes_m  = '0;
         rslt_m   = '0;
         rst_seen = 1'b1;
      end else begin
         if (rst_seen) begin   // first edge out of reset.
            ok = 1'b1;
            compare_word("busy_o", prod_t'(busy_i), '0, ok);
            compare_word("done_o", prod_t'(done_i), '0, ok);
            compare_outputs('0, ok);
            test_cnt++;
            if (ok) pass_cnt++;
            else fail_cnt++;
            $display("test %0d reset state: %s", test_cnt, ok ? "ok" : "mismatch");
            rst_seen = 1'b0;
         end
         if (done_i) begin
            test_cnt++;
            if (pend_q.size() == 0) begin
               $display("test %0d: done_o pulsed with no accepted request outstanding",
                        test_cnt);
               fail_cnt++;
            end else begin
               r  = pend_q.pop_front();
               ok = 1'b1;
               ref_op(r, lanes_m, rslt_m, flag_m);
               compare_outputs(flag_m, ok);
               if (ok) pass_cnt++;
               else fail_cnt++;
               $display("test %0d %s lane %0d: %s", test_cnt, r.cmd.name(), r.lane,
                        ok ? "ok" : "mismatch");
            end
         end
         if (req_i && !busy_i) begin
            pend_q.push_back('{cmd: cmd_i, x: x_i, y: y_i, z: z_i, lane: w_i[LANE_W-1:0]});
         end
      end
      pend_cnt = pend_q.size();
   end

endmodule

/* sim/fma_tb.sv */
module fma_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import fma_cfg_pkg::*;
   import fma_cmd_pkg::*;

   localparam int MUL_LAT  = MUL_LAT_DEF;
   localparam int WAIT_MAX = 20;   // cycles before a wait gives up.

   logic        clk = 1'b0;
   logic        rst;
   logic        req;
   cmd_e        cmd;
   operand_t    x;
   operand_t    y;
   operand_t    z;
   operand_t    w;
   logic        busy;
   logic        done;
   prod_t       rslt;
   flag_t       flag;
   operand_t    acc0;
   operand_t    acc1;
   operand_t    acc2;
   operand_t    acc3;
   int          mon_pass;
   int          mon_fail;
   int          mon_pend;
   int          wait_err = 0;
   int          chk_fail;
   logic [31:0] lfsr_q = 32'd92;

   fma_unit #(.MUL_LAT(MUL_LAT)) i_fma_unit (
      .clk_i (clk), .rst_i (rst), .req_i (req), .req_command_i (cmd),
      .x_i (x), .y_i (y), .z_i (z), .w_i (w),
      .busy_o (busy), .done_o (done), .rslt_o (rslt), .flag_o (flag),
      .acc0_o (acc0), .acc1_o (acc1), .acc2_o (acc2), .acc3_o (acc3)
   );

   fma_mon i_fma_mon (
      .clk_i (clk), .rst_i (rst), .req_i (req), .cmd_i (cmd),
      .x_i (x), .y_i (y), .z_i (z), .w_i (w),
      .busy_i (busy), .done_i (done), .rslt_i (rslt), .flag_i (flag),
      .acc0_i (acc0), .acc1_i (acc1), .acc2_i (acc2), .acc3_i (acc3),
      .pass_cnt_o (mon_pass), .fail_cnt_o (mon_fail), .pend_cnt_o (mon_pend)
   );

   bind fma_ctrl fma_chk #(.MUL_LAT(MUL_LAT)) i_fma_chk (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .req_i  (req_i),
      .busy_i (busy_o),
      .done_i (done_o)
   );

   always #5 clk = ~clk;

   // fibonacci lfsr, taps 32 22 2 1.
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v      = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   task automatic wait_idle();
      int n;
      n = 0;
      while (busy && n < WAIT_MAX) begin
         @(negedge clk);
         n++;
      end
      if (busy) begin
         $display("timeout: busy_o did not fall within %0d cycles", WAIT_MAX);
         wait_err++;
      end
   endtask

   task automatic wait_done();
      int n;
      n = 0;
      while (!done && n < WAIT_MAX) begin
         @(negedge clk);
         n++;
      end
      if (!done) begin
         $display("timeout: done_o did not rise within %0d cycles", WAIT_MAX);
         wait_err++;
      end
   endtask

   task automatic issue(input cmd_e c, input operand_t xv, input operand_t yv,
                        input operand_t zv, input operand_t wv);
      wait_idle();
      req = 1'b1;
      cmd = c;
      x   = xv;
      y   = yv;
      z   = zv;
      w   = wv;
      @(negedge clk);
      req = 1'b0;
   endtask

   task automatic run_op(input cmd_e c, input operand_t xv, input operand_t yv,
                         input operand_t zv, input operand_t wv);
      issue(c, xv, yv, zv, wv);
      wait_done();
   endtask

   // second request lands while the first is in flight and must be dropped.
   task automatic run_with_stray(input cmd_e c, input operand_t xv, input operand_t wv,
                                 input cmd_e sc, input operand_t sx, input operand_t sw);
      issue(c, xv, rand_bits(32), rand_bits(32), wv);
      req = 1'b1;
      cmd = sc;
      x   = sx;
      y   = 32'd1;
      w   = sw;
      @(negedge clk);
      req = 1'b0;
      wait_done();
   endtask

   // ************************************************************************
   // test sequence
   // ************************************************************************

   initial begin
      rst = 1'b1;
      req = 1'b0;
      cmd = CMD_MADD;
      x   = '0;
      y   = '0;
      z   = '0;
      w   = '0;
      repeat (8) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);

      for (int i = 0; i < 20; i++) begin
         run_op(CMD_MADD, rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32));
      end
      for (int i = 0; i < 8; i++) begin   // z above x*y, so the result goes negative.
         run_op(CMD_MSUB, rand_bits(12), rand_bits(12), 32'h8000_0000 | rand_bits(31),
                rand_bits(32));
      end
      for (int i = 0; i < 8; i++) begin
         run_op(CMD_MSUB, rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32));
      end
      for (int lane = 0; lane < LANES; lane++) begin
         for (int i = 0; i < 3; i++) begin
            run_op(CMD_MAC, rand_bits(32), rand_bits(32), rand_bits(32),
                   (rand_bits(30) << 2) | lane);
         end
         for (int i = 0; i < 2; i++) begin   // two big addends always carry.
            run_op(CMD_MAC, 32'hC000_0000 | rand_bits(28), 32'd1, rand_bits(32),
                   (rand_bits(30) << 2) | lane);
         end
      end

      run_op(CMD_MAC, 32'hFFFF_FFFF, 32'd1, '0, 32'd3);
      run_op(CMD_CLR, rand_bits(32), rand_bits(32), rand_bits(32), 32'd3);
      run_op(CMD_CLR, rand_bits(32), rand_bits(32), rand_bits(32), 32'd1);
      run_op(CMD_MAC, rand_bits(16), rand_bits(16), rand_bits(32), 32'd1);
      run_op(CMD_CLR, rand_bits(32), rand_bits(32), rand_bits(32), 32'd0);

      run_with_stray(CMD_MADD, rand_bits(32), 32'd0, CMD_MAC, 32'hF000_0000, 32'd2);
      run_with_stray(CMD_MAC, rand_bits(32), 32'd2, CMD_CLR, '0, 32'd2);
      run_with_stray(CMD_MSUB, rand_bits(32), 32'd1, CMD_MADD, rand_bits(32), 32'd1);
      run_op(CMD_MAC, rand_bits(32), rand_bits(32), '0, 32'd2);
      wait_idle();

      chk_fail = i_fma_unit.i_fma_ctrl.i_fma_chk.fail_cnt;
      if (mon_pend != 0) begin
         $display("%0d accepted requests never completed", mon_pend);
         wait_err++;
      end
      $display("tests: %0d passed, %0d failed, %0d timeouts, %0d assertion failures",
               mon_pass, mon_fail, wait_err, chk_fail);
      if (mon_fail == 0 && wait_err == 0 && chk_fail == 0 && mon_pass > 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

/* files.f */
common/fma_cfg_pkg.sv
common/fma_cmd_pkg.sv
common/fma_if.sv
datapath/mul_pipe.sv
datapath/add_stage.sv
datapath/acc_bank.sv
hdl/step_timer.sv
hdl/fma_ctrl.sv
hdl/fma_unit.sv
sim/fma_chk.sv
sim/fma_mon.sv
sim/fma_tb.sv

/* Bender.yml */
package:
  name: fma_unit

sources:
  - common/fma_cfg_pkg.sv
  - common/fma_cmd_pkg.sv
  - common/fma_if.sv
  - datapath/mul_pipe.sv
  - datapath/add_stage.sv
  - datapath/acc_bank.sv
  - hdl/step_timer.sv
  - hdl/fma_ctrl.sv
  - hdl/fma_unit.sv
  - target: test
    files:
      - sim/fma_chk.sv
      - sim/fma_mon.sv
      - sim/fma_tb.sv
